/* include/rob_defs.svh */
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// number of reorder buffer entries
`define ROB_DEPTH 16

// entry index width, log2 of the depth
`define ROB_TAG_W 4

// result data width
`define XLEN 32

// program counter width
`define ADDR_W 32

// architectural register index width
`define REG_IDX_W 5

`endif

/* hw/rob_pkg.sv */
`include "rob_defs.svh"

package rob_pkg;

    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // one more bit than the tag so a full buffer is representable
    typedef logic [`ROB_TAG_W:0] rob_cnt_t;

    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`XLEN-1:0] xdata_t;
    typedef logic [`ADDR_W-1:0] pc_t;

    // allocation request from dispatch
    typedef struct packed {
        reg_idx_t rd;
        logic     is_store;
        logic     is_branch;
        logic     pred_taken;
    } alloc_req_t;

    // result from an execution unit
    typedef struct packed {
        rob_tag_t tag;
        xdata_t   data;
        logic     taken;
        pc_t      target;
    } complete_t;

    // retiring entry, to register file or store buffer
    typedef struct packed {
        rob_tag_t tag;
        reg_idx_t rd;
        xdata_t   data;
        logic     is_store;
    } commit_t;

    typedef enum logic {
        RUN,
        FLUSH
    } rob_state_e;

endpackage

/* hw/rob_ctrl.sv */
`timescale 1ns/1ps

module rob_ctrl (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         head_done,
    input  logic         head_mispredict,
    input  rob_pkg::pc_t head_target,
    input  logic         full,
    input  logic         empty,
    input  logic         commit_ready,
    input  logic         alloc_valid,
    output logic         commit_valid,
    output logic         alloc_ready,
    output logic         alloc_fire,
    output logic         retire,
    output logic         clear,
    output logic         flush,
    output rob_pkg::pc_t redirect_pc
);

    rob_pkg::rob_state_e state;
    rob_pkg::rob_state_e state_nxt;
    rob_pkg::pc_t        redirect_q;
    logic                running;
    logic                mispredict_retire;

    assign running = (state == rob_pkg::RUN);

    // handshakes only open while running
    assign commit_valid = running && !empty && head_done;
    assign retire       = commit_valid && commit_ready;
    assign alloc_ready  = running && !full;
    assign alloc_fire   = alloc_valid && alloc_ready;

    assign mispredict_retire = retire && head_mispredict;

    // one cycle of recovery after the bad branch has left
    assign clear       = (state == rob_pkg::FLUSH);
    assign flush       = clear;
    assign redirect_pc = redirect_q;

    always_comb begin
        state_nxt = state;
        case (state)
            rob_pkg::RUN: begin
                if (mispredict_retire) begin
                    state_nxt = rob_pkg::FLUSH;
                end
            end
            rob_pkg::FLUSH: begin
                state_nxt = rob_pkg::RUN;
            end
            default: begin
                state_nxt = rob_pkg::RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rob_pkg::RUN;
        end else begin
            state <= state_nxt;
        end
    end

    // target of the retiring branch, shown during flush
    always_ff @(posedge clk) begin
        if (mispredict_retire) begin
            redirect_q <= head_target;
        end
    end

endmodule

/* hw/rob_ptr.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_ptr (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc_fire,
    input  logic              retire,
    input  logic              clear,
    output rob_pkg::rob_tag_t head,
    output rob_pkg::rob_tag_t tail,
    output rob_pkg::rob_cnt_t count,
    output logic              full,
    output logic              empty
);

    // depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
        end else if (clear) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (alloc_fire) begin
                tail <= tail + rob_pkg::rob_tag_t'(1);
            end
            if (retire) begin
                head <= head + rob_pkg::rob_tag_t'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else begin
            case ({alloc_fire, retire})
                2'b10: begin
                    count <= count + rob_pkg::rob_cnt_t'(1);
                end
                2'b01: begin
                    count <= count - rob_pkg::rob_cnt_t'(1);
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    assign full  = (count == rob_pkg::rob_cnt_t'(`ROB_DEPTH));
    assign empty = (count == '0);

endmodule

/* hw/rob_entries.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_entries (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                alloc_fire,
    input  rob_pkg::alloc_req_t alloc,
    input  rob_pkg::rob_tag_t   tail,
    input  rob_pkg::rob_tag_t   head,
    input  logic                retire,
    input  logic                clear,
    input  logic                cmpl_valid,
    input  rob_pkg::complete_t  cmpl,
    output rob_pkg::commit_t    commit,
    output logic                head_done,
    output logic                head_mispredict,
    output rob_pkg::pc_t        head_target
);

    // per entry flags
    logic [`ROB_DEPTH-1:0] busy;
    logic [`ROB_DEPTH-1:0] done;

    // per entry payload
    rob_pkg::reg_idx_t rd_mem         [`ROB_DEPTH];
    logic              is_store_mem   [`ROB_DEPTH];
    logic              is_branch_mem  [`ROB_DEPTH];
    logic              pred_taken_mem [`ROB_DEPTH];
    rob_pkg::xdata_t   data_mem       [`ROB_DEPTH];
    logic              taken_mem      [`ROB_DEPTH];
    rob_pkg::pc_t      target_mem     [`ROB_DEPTH];

    logic cmpl_hit;

    // late or repeated results are dropped
    assign cmpl_hit = cmpl_valid && busy[cmpl.tag] && !done[cmpl.tag];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else if (clear) begin
            busy <= '0;
        end else begin
            if (alloc_fire) begin
                busy[tail] <= 1'b1;
            end
            if (retire) begin
                busy[head] <= 1'b0;
            end
        end
    end

    // tail is never busy when alloc fires, so no clash with a completion
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= '0;
        end else begin
            if (alloc_fire) begin
                done[tail] <= 1'b0;
            end
            if (cmpl_hit) begin
                done[cmpl.tag] <= 1'b1;
            end
        end
    end

    // request fields written at allocation
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            rd_mem[tail]         <= alloc.rd;
            is_store_mem[tail]   <= alloc.is_store;
            is_branch_mem[tail]  <= alloc.is_branch;
            pred_taken_mem[tail] <= alloc.pred_taken;
        end
    end

    // result fields written at completion
    always_ff @(posedge clk) begin
        if (cmpl_hit) begin
            data_mem[cmpl.tag]   <= cmpl.data;
            taken_mem[cmpl.tag]  <= cmpl.taken;
            target_mem[cmpl.tag] <= cmpl.target;
        end
    end

    assign head_done = busy[head] && done[head];

    assign head_mispredict = is_branch_mem[head] &&
                             (taken_mem[head] != pred_taken_mem[head]);

    assign head_target = target_mem[head];

    always_comb begin
        commit          = '0;
        commit.tag      = head;
        commit.rd       = rd_mem[head];
        commit.data     = data_mem[head];
        commit.is_store = is_store_mem[head];
    end

endmodule

/* hw/rob_top.sv */
`timescale 1ns/1ps

module rob_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                alloc_valid,
    output logic                alloc_ready,
    input  rob_pkg::alloc_req_t alloc,
    output rob_pkg::rob_tag_t   alloc_tag,
    input  logic                cmpl_valid,
    input  rob_pkg::complete_t  cmpl,
    output logic                commit_valid,
    input  logic                commit_ready,
    output rob_pkg::commit_t    commit,
    output logic                flush,
    output rob_pkg::pc_t        redirect_pc
);

    logic              alloc_fire;
    logic              retire;
    logic              clear;
    logic              full;
    logic              empty;
    logic              head_done;
    logic              head_mispredict;
    rob_pkg::pc_t      head_target;
    rob_pkg::rob_tag_t head;
    rob_pkg::rob_tag_t tail;

    // new entries always land at the tail
    assign alloc_tag = tail;

    rob_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .head_done       (head_done),
        .head_mispredict (head_mispredict),
        .head_target     (head_target),
        .full            (full),
        .empty           (empty),
        .commit_ready    (commit_ready),
        .alloc_valid     (alloc_valid),
        .commit_valid    (commit_valid),
        .alloc_ready     (alloc_ready),
        .alloc_fire      (alloc_fire),
        .retire          (retire),
        .clear           (clear),
        .flush           (flush),
        .redirect_pc     (redirect_pc)
    );

    rob_ptr u_ptr (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_fire (alloc_fire),
        .retire     (retire),
        .clear      (clear),
        .head       (head),
        .tail       (tail),
        .count      (),
        .full       (full),
        .empty      (empty)
    );

    rob_entries u_entries (
        .clk             (clk),
        .rst_n           (rst_n),
        .alloc_fire      (alloc_fire),
        .alloc           (alloc),
        .tail            (tail),
        .head            (head),
        .retire          (retire),
        .clear           (clear),
        .cmpl_valid      (cmpl_valid),
        .cmpl            (cmpl),
        .commit          (commit),
        .head_done       (head_done),
        .head_mispredict (head_mispredict),
        .head_target     (head_target)
    );

endmodule

/* dv/rob_tb.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_tb;

    localparam int NUM_ROWS   = 40;
    localparam int WAIT_LIMIT = 100;

    // commit_ready per cycle of the commit phase starting at the lsb
    localparam logic [15:0] READY_PAT = 16'b1101_0011_1011_0110;

    typedef struct packed {
        rob_pkg::reg_idx_t rd;
        logic              is_store;
        logic              is_branch;
        logic              pred_taken;
        logic              actual_taken;
        rob_pkg::pc_t      target;
        rob_pkg::xdata_t   data;
    } row_t;

    logic                clk;
    logic                rst_n;
    logic                alloc_valid;
    logic                alloc_ready;
    rob_pkg::alloc_req_t alloc;
    rob_pkg::rob_tag_t   alloc_tag;
    logic                cmpl_valid;
    rob_pkg::complete_t  cmpl;
    logic                commit_valid;
    logic                commit_ready;
    rob_pkg::commit_t    commit;
    logic                flush;
    rob_pkg::pc_t        redirect_pc;

    row_t              rows [NUM_ROWS];
    // rows held in the buffer in age order
    int                pend_rows [$];
    rob_pkg::rob_tag_t pend_tags [$];
    rob_pkg::rob_tag_t exp_tail;
    logic [31:0]       rng_state;
    logic [3:0]        pat_idx;
    logic              flush_due;
    int                next_row;

    rob_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [95:0] actual,
                             input logic [95:0] expected);
        if (actual !== expected) begin
            $display("Error: time %0t signal %s expected %0h actual %0h",
                     $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: waited %0d cycles for %s", WAIT_LIMIT, what);
        $display("Test failures found");
        $fatal(1, "stopping on timeout");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic is_mispredict(input row_t r);
        return r.is_branch && (r.actual_taken != r.pred_taken);
    endfunction

    // advance to the next falling edge and run the per-cycle checks
    task automatic next_cycle();
        logic             stall;
        logic             exp_flush;
        rob_pkg::commit_t held;
        stall     = commit_valid && !commit_ready;
        held      = commit;
        exp_flush = flush_due;
        flush_due = 1'b0;
        @(negedge clk);
        check_val("flush", 96'(flush), 96'(exp_flush));
        if (stall) begin
            check_val("commit_valid", 96'(commit_valid), 96'(1'b1));
            check_val("commit", 96'(commit), 96'(held));
        end
    endtask

    // fill from the table while commits are held off
    task automatic alloc_batch();
        int   wait_cnt;
        row_t cur;
        commit_ready = 1'b0;
        while (next_row < NUM_ROWS && pend_rows.size() < `ROB_DEPTH) begin
            wait_cnt = 0;
            while (!alloc_ready) begin
                if (wait_cnt == WAIT_LIMIT) begin
                    timeout_fail("alloc_ready");
                end
                wait_cnt++;
                next_cycle();
            end
            check_val("alloc_tag", 96'(alloc_tag), 96'(exp_tail));
            cur         = rows[next_row];
            alloc       = '{cur.rd, cur.is_store, cur.is_branch, cur.pred_taken};
            alloc_valid = 1'b1;
            pend_rows.push_back(next_row);
            pend_tags.push_back(exp_tail);
            exp_tail = exp_tail + rob_pkg::rob_tag_t'(1);
            next_row++;
            next_cycle();
        end
        // a full buffer refuses the next request
        if (pend_rows.size() == `ROB_DEPTH) begin
            check_val("alloc_ready", 96'(alloc_ready), 96'(1'b0));
            next_cycle();
            check_val("alloc_ready", 96'(alloc_ready), 96'(1'b0));
        end
        alloc_valid = 1'b0;
    endtask

    // results in shuffled order and then a stale repeat that must be dropped
    task automatic complete_batch();
        int   order [$];
        int   i;
        int   j;
        int   tmp;
        row_t cur;
        for (i = 0; i < pend_rows.size(); i++) begin
            order.push_back(i);
        end
        for (i = order.size() - 1; i > 0; i--) begin
            rng_state = xorshift32(rng_state);
            j         = int'(rng_state % 32'(i + 1));
            tmp       = order[i];
            order[i]  = order[j];
            order[j]  = tmp;
        end
        for (i = 0; i < order.size(); i++) begin
            cur        = rows[pend_rows[order[i]]];
            cmpl       = '{pend_tags[order[i]], cur.data, cur.actual_taken, cur.target};
            cmpl_valid = 1'b1;
            next_cycle();
        end
        cur        = rows[pend_rows[order[0]]];
        cmpl       = '{pend_tags[order[0]], ~cur.data, ~cur.actual_taken, cur.target};
        next_cycle();
        cmpl_valid = 1'b0;
        check_val("commit_valid", 96'(commit_valid), 96'(1'b1));
        // stalled head must hold still
        repeat (3) next_cycle();
    endtask

    // retire under the ready pattern and follow the model order
    task automatic commit_batch();
        int                wait_cnt;
        int                r;
        rob_pkg::rob_tag_t t;
        logic              flushed;
        wait_cnt = 0;
        flushed  = 1'b0;
        while (pend_rows.size() > 0 && !flushed) begin
            if (wait_cnt == WAIT_LIMIT) begin
                timeout_fail("the pending rows to commit");
            end
            wait_cnt++;
            commit_ready = READY_PAT[pat_idx];
            pat_idx      = pat_idx + 4'd1;
            if (commit_valid && commit_ready) begin
                r = pend_rows.pop_front();
                t = pend_tags.pop_front();
                check_val("commit.tag", 96'(commit.tag), 96'(t));
                check_val("commit.rd", 96'(commit.rd), 96'(rows[r].rd));
                check_val("commit.data", 96'(commit.data), 96'(rows[r].data));
                check_val("commit.is_store", 96'(commit.is_store), 96'(rows[r].is_store));
                if (is_mispredict(rows[r])) begin
                    // younger rows are lost and go again
                    flushed   = 1'b1;
                    flush_due = 1'b1;
                    next_row  = r + 1;
                    pend_rows.delete();
                    pend_tags.delete();
                    next_cycle();
                    commit_ready = 1'b0;
                    check_val("redirect_pc", 96'(redirect_pc), 96'(rows[r].target));
                    check_val("commit_valid", 96'(commit_valid), 96'(1'b0));
                    check_val("alloc_ready", 96'(alloc_ready), 96'(1'b0));
                    next_cycle();
                    exp_tail = '0;
                    check_val("commit_valid", 96'(commit_valid), 96'(1'b0));
                    check_val("alloc_ready", 96'(alloc_ready), 96'(1'b1));
                    check_val("alloc_tag", 96'(alloc_tag), 96'(exp_tail));
                end
            end
            if (!flushed) begin
                next_cycle();
            end
        end
        commit_ready = 1'b0;
    endtask

    // rd, is_store, is_branch, pred_taken, actual_taken, target, data
    task automatic load_table();
        rows[0]  = '{5'd1,  1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4000, 32'hd0a0_0000};
        rows[1]  = '{5'd2,  1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4010, 32'hd0a0_0001};
        rows[2]  = '{5'd0,  1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_4020, 32'hd0a0_0002};
        rows[3]  = '{5'd3,  1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_4030, 32'hd0a0_0003};
        rows[4]  = '{5'd4,  1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4040, 32'hd0a0_0004};
        rows[5]  = '{5'd0,  1'b0, 1'b1, 1'b1, 1'b1, 32'h0000_4050, 32'hd0a0_0005};
        rows[6]  = '{5'd5,  1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4060, 32'hd0a0_0006};
        rows[7]  = '{5'd0,  1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_4070, 32'hd0a0_0007};
        rows[8]  = '{5'd6,  1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4080, 32'hd0a0_0008};
        rows[9]  = '{5'd0,  1'b0, 1'b1, 1'b0, 1'b0, 32'h0000_4090, 32'hd0a0_0009};
        rows[10] = '{5'd7,  1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_40a0, 32'hd0a0_000a};
        rows[11] = '{5'd0,  1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_40b0, 32'hd0a0_000b};
        rows[12] = '{5'd8,  1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_40c0, 32'hd0a0_000c};
        rows[13] = '{5'd9,  1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_40d0, 32'hd0a0_000d};
        rows[14] = '{5'd10, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_40e0, 32'hd0a0_000e};
        rows[15] = '{5'd11, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_40f0, 32'hd0a0_000f};
        rows[16] = '{5'd12, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4100, 32'hd0a0_0010};
        rows[17] = '{5'd13, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4110, 32'hd0a0_0011};
        rows[18] = '{5'd0,  1'b0, 1'b1, 1'b1, 1'b1, 32'h0000_4120, 32'hd0a0_0012};
        rows[19] = '{5'd14, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4130, 32'hd0a0_0013};
        rows[20] = '{5'd0,  1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_4140, 32'hd0a0_0014};
        rows[21] = '{5'd15, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4150, 32'hd0a0_0015};
        rows[22] = '{5'd0,  1'b0, 1'b1, 1'b0, 1'b1, 32'h0000_4160, 32'hd0a0_0016};
        rows[23] = '{5'd16, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4170, 32'hd0a0_0017};
        rows[24] = '{5'd17, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4180, 32'hd0a0_0018};
        rows[25] = '{5'd18, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4190, 32'hd0a0_0019};
        rows[26] = '{5'd0,  1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_41a0, 32'hd0a0_001a};
        rows[27] = '{5'd0,  1'b0, 1'b1, 1'b0, 1'b0, 32'h0000_41b0, 32'hd0a0_001b};
        rows[28] = '{5'd19, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_41c0, 32'hd0a0_001c};
        rows[29] = '{5'd20, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_41d0, 32'hd0a0_001d};
        rows[30] = '{5'd0,  1'b0, 1'b1, 1'b1, 1'b0, 32'h0000_41e0, 32'hd0a0_001e};
        rows[31] = '{5'd21, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_41f0, 32'hd0a0_001f};
        rows[32] = '{5'd22, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4200, 32'hd0a0_0020};
        rows[33] = '{5'd0,  1'b1, 1'b0, 1'b0, 1'b1, 32'h0000_4210, 32'hd0a0_0021};
        rows[34] = '{5'd23, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4220, 32'hd0a0_0022};
        rows[35] = '{5'd0,  1'b0, 1'b1, 1'b0, 1'b0, 32'h0000_4230, 32'hd0a0_0023};
        rows[36] = '{5'd24, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4240, 32'hd0a0_0024};
        rows[37] = '{5'd25, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4250, 32'hd0a0_0025};
        rows[38] = '{5'd31, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_4260, 32'hd0a0_0026};
        rows[39] = '{5'd0,  1'b0, 1'b1, 1'b0, 1'b1, 32'h0000_4270, 32'hd0a0_0027};
    endtask

    initial begin
        rst_n        = 1'b0;
        alloc_valid  = 1'b0;
        alloc        = '0;
        cmpl_valid   = 1'b0;
        cmpl         = '0;
        commit_ready = 1'b0;
        rng_state    = 32'h0c93d605;
        pat_idx      = '0;
        flush_due    = 1'b0;
        exp_tail     = '0;
        next_row     = 0;
        load_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_val("commit_valid", 96'(commit_valid), 96'(1'b0));
        check_val("flush", 96'(flush), 96'(1'b0));
        check_val("alloc_ready", 96'(alloc_ready), 96'(1'b1));
        check_val("alloc_tag", 96'(alloc_tag), 96'(0));
        while (next_row < NUM_ROWS) begin
            alloc_batch();
            complete_batch();
            commit_batch();
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
hw/rob_pkg.sv
hw/rob_ctrl.sv
hw/rob_ptr.sv
hw/rob_entries.sv
hw/rob_top.sv
dv/rob_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the reorder buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f vlog.f --top-module rob_tb -Mdir obj_dir -o rob_sim

./obj_dir/rob_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi
